// ==== common/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Datapath and memory port widths shared by the core and the testbench

`define RV_XLEN        32 // Register and data word width
`define RV_ADDR_WIDTH  10 // Word index width on ROM and RAM ports
`define RV_REG_COUNT   32 // Architectural registers x0..x31
`define RV_REG_IDX_W   5  // Bits in a register index

`endif

// ==== common/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Major opcode in bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        OP     = 7'b0110011, // Register-register ALU
        OP_IMM = 7'b0010011, // Register-immediate ALU
        LOAD   = 7'b0000011, // Only LW
        STORE  = 7'b0100011, // Only SW
        BRANCH = 7'b1100011, // Only BEQ and BNE
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111
    } rv_opcode_e;

    // Operation selected for the ALU
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3, // Signed compare
        SLTU = 4'd4, // Unsigned compare
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7, // Keeps the sign bit
        OR   = 4'd8,
        AND  = 4'd9
    } rv_alu_op_e;

    // Branch kind as encoded in funct3
    typedef enum logic [2:0] {
        BEQ = 3'b000,
        BNE = 3'b001
    } rv_branch_e;

endpackage

// ==== common/rv_core_pkg.sv ====
`include "rv_settings.svh"

package rv_core_pkg;

    // Source of ALU operand A
    typedef enum logic [1:0] {
        OPA_REG  = 2'd0, // rs1 value
        OPA_PC   = 2'd1, // For AUIPC
        OPA_ZERO = 2'd2  // For LUI
    } rv_op_a_e;

    // Source of the register write-back value
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2 // Link value of JAL
    } rv_wb_sel_e;

    // Control fields from the decoder to the execute unit and the top
    typedef struct packed {
        rv_isa_pkg::rv_alu_op_e alu_op;
        rv_op_a_e               op_a;
        logic                   op_b_imm;  // Operand B from immediate
        rv_wb_sel_e             wb_sel;
        logic                   reg_we;
        logic                   mem_we;
        logic                   is_branch;
        logic                   branch_ne; // BNE when set, else BEQ
        logic                   is_jump;
    } rv_ctrl_t;

    typedef struct packed {
        logic [`RV_REG_IDX_W-1:0] rs1;
        logic [`RV_REG_IDX_W-1:0] rs2;
        logic [`RV_REG_IDX_W-1:0] rd;
    } rv_regsel_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] rs1_val;
        logic [`RV_XLEN-1:0] rs2_val;
    } rv_operands_t;

endpackage

// ==== decode/rv_decoder.sv ====
`timescale 1ns/100ps

`include "rv_settings.svh"

module rv_decoder
    import rv_isa_pkg::*, rv_core_pkg::*;
(
    input  logic [`RV_XLEN-1:0] instr,
    output rv_ctrl_t            ctrl,
    output logic [`RV_XLEN-1:0] imm
);

    rv_opcode_e  opcode;
    logic [2:0]  funct3;
    logic        alt;   // Bit 30 selects SUB and SRA

    assign opcode = rv_opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign alt    = instr[30];

    // ALU operation from funct3 and bit 30 with SUB allowed only when alt_ok is set
    function automatic rv_alu_op_e alu_op_of(input logic [2:0] f3, input logic alt_bit,
                                             input logic alt_ok);
        rv_alu_op_e op;
        case (f3)
            3'b000:  op = (alt_bit && alt_ok) ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = alt_bit ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    // Immediate formats
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;

    assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    always_comb begin
        // Defaults leave registers and memory unchanged
        ctrl.alu_op    = ADD;
        ctrl.op_a      = OPA_REG;
        ctrl.op_b_imm  = 1'b0;
        ctrl.wb_sel    = WB_ALU;
        ctrl.reg_we    = 1'b0;
        ctrl.mem_we    = 1'b0;
        ctrl.is_branch = 1'b0;
        ctrl.branch_ne = 1'b0;
        ctrl.is_jump   = 1'b0;
        imm            = '0;

        case (opcode)
            OP: begin
                ctrl.alu_op = alu_op_of(funct3, alt, 1'b1);
                ctrl.reg_we = 1'b1;
            end
            OP_IMM: begin
                ctrl.alu_op   = alu_op_of(funct3, alt, 1'b0); // No SUBI
                ctrl.op_b_imm = 1'b1;
                ctrl.reg_we   = 1'b1;
                imm           = imm_i;
            end
            LOAD: begin
                ctrl.op_b_imm = 1'b1;
                ctrl.wb_sel   = WB_MEM;
                ctrl.reg_we   = 1'b1;
                imm           = imm_i;
            end
            STORE: begin
                ctrl.op_b_imm = 1'b1;
                ctrl.mem_we   = 1'b1;
                imm           = imm_s;
            end
            BRANCH: begin
                ctrl.alu_op    = SUB;
                ctrl.is_branch = (funct3 == BEQ) || (funct3 == BNE);
                ctrl.branch_ne = (funct3 == BNE);
                imm            = imm_b;
            end
            LUI: begin
                ctrl.op_a     = OPA_ZERO;
                ctrl.op_b_imm = 1'b1;
                ctrl.reg_we   = 1'b1;
                imm           = imm_u;
            end
            AUIPC: begin
                ctrl.op_a     = OPA_PC;
                ctrl.op_b_imm = 1'b1;
                ctrl.reg_we   = 1'b1;
                imm           = imm_u;
            end
            JAL: begin
                ctrl.wb_sel  = WB_PC4;
                ctrl.reg_we  = 1'b1;
                ctrl.is_jump = 1'b1;
                imm          = imm_j;
            end
            default: ; // Unknown opcode acts as a no-op
        endcase
    end

endmodule

// ==== hw/rv_regfile.sv ====
`timescale 1ns/100ps

`include "rv_settings.svh"

module rv_regfile
    import rv_core_pkg::*;
(
    input  logic                CLK,
    input  logic                RESET_N,
    input  rv_regsel_t          regsel,
    input  logic                wr_en,
    input  logic [`RV_XLEN-1:0] wr_data,
    output rv_operands_t        operands
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (regsel.rd != '0)) begin // x0 ignores writes
            regs[regsel.rd] <= wr_data;
        end
    end

    // Combinational reads with x0 tied to zero
    always_comb begin
        operands.rs1_val = (regsel.rs1 == '0) ? '0 : regs[regsel.rs1];
        operands.rs2_val = (regsel.rs2 == '0) ? '0 : regs[regsel.rs2];
    end

endmodule

// ==== execute/rv_execute.sv ====
`timescale 1ns/100ps

`include "rv_settings.svh"

module rv_execute
    import rv_isa_pkg::*, rv_core_pkg::*;
(
    input  logic [`RV_XLEN-1:0] pc,
    input  rv_ctrl_t            ctrl,
    input  logic [`RV_XLEN-1:0] imm,
    input  rv_operands_t        operands,
    input  logic [`RV_XLEN-1:0] mem_data,
    output logic [`RV_XLEN-1:0] alu_result,
    output logic [`RV_XLEN-1:0] wb_data,
    output logic [`RV_XLEN-1:0] next_pc
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] pc_target;
    logic                rs_equal;
    logic                take_branch;

    // Operand selection
    always_comb begin
        case (ctrl.op_a)
            OPA_PC:   op_a = pc;
            OPA_ZERO: op_a = '0;
            default:  op_a = operands.rs1_val;
        endcase
    end

    assign op_b  = ctrl.op_b_imm ? imm : operands.rs2_val;
    assign shamt = op_b[4:0]; // Only low five bits shift

    // ALU
    always_comb begin
        case (ctrl.alu_op)
            ADD:     alu_result = op_a + op_b;
            SUB:     alu_result = op_a - op_b;
            SLL:     alu_result = op_a << shamt;
            SLT:     alu_result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLTU:    alu_result = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            XOR:     alu_result = op_a ^ op_b;
            SRL:     alu_result = op_a >> shamt;
            SRA:     alu_result = $unsigned($signed(op_a) >>> shamt);
            OR:      alu_result = op_a | op_b;
            AND:     alu_result = op_a & op_b;
            default: alu_result = '0;
        endcase
    end

    // Branch decision uses the raw register values
    assign rs_equal    = (operands.rs1_val == operands.rs2_val);
    assign take_branch = ctrl.is_branch && (rs_equal != ctrl.branch_ne);

    assign pc_plus4  = pc + `RV_XLEN'd4;
    assign pc_target = pc + imm; // Branch and JAL target

    assign next_pc = (take_branch || ctrl.is_jump) ? pc_target : pc_plus4;

    // Write-back selection
    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:  wb_data = mem_data;
            WB_PC4:  wb_data = pc_plus4;
            default: wb_data = alu_result;
        endcase
    end

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/100ps

`include "rv_settings.svh"

module rv_core
    import rv_core_pkg::*;
(
    input  logic                      CLK,
    input  logic                      RESET_N,
    input  logic [`RV_XLEN-1:0]       q_rom,
    output logic [`RV_ADDR_WIDTH-1:0] addr_rom,
    output logic [`RV_ADDR_WIDTH-1:0] addr_ram,
    input  logic [`RV_XLEN-1:0]       q_ram,
    output logic [`RV_XLEN-1:0]       q_w,
    output logic                      enable_w
);

    logic [`RV_XLEN-1:0] pc;       // Byte address
    logic                run;      // Set one edge after reset release
    rv_regsel_t          regsel;
    rv_ctrl_t            ctrl;
    logic [`RV_XLEN-1:0] imm;
    rv_operands_t        operands;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] wb_data;
    logic [`RV_XLEN-1:0] next_pc;

    assign regsel = '{rs1: q_rom[19:15], rs2: q_rom[24:20], rd: q_rom[11:7]};

    rv_decoder i_rv_decoder (
        .instr (q_rom),
        .ctrl  (ctrl),
        .imm   (imm)
    );

    rv_regfile i_rv_regfile (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .regsel   (regsel),
        .wr_en    (ctrl.reg_we & run), // No write before the first instruction
        .wr_data  (wb_data),
        .operands (operands)
    );

    rv_execute i_rv_execute (
        .pc         (pc),
        .ctrl       (ctrl),
        .imm        (imm),
        .operands   (operands),
        .mem_data   (q_ram),
        .alu_result (alu_result),
        .wb_data    (wb_data),
        .next_pc    (next_pc)
    );

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc  <= '0;
            run <= 1'b0;
        end else begin
            run <= 1'b1;
            if (run) begin
                pc <= next_pc; // PC holds at zero until running
            end
        end
    end

    // Word indices from byte addresses
    assign addr_rom = pc[`RV_ADDR_WIDTH+1:2];
    assign addr_ram = alu_result[`RV_ADDR_WIDTH+1:2];
    assign q_w      = operands.rs2_val;
    assign enable_w = ctrl.mem_we & run;

endmodule

// ==== verification/rv_core_checker.sv ====
`timescale 1ns/100ps

`include "rv_settings.svh"

module rv_core_checker
    import rv_isa_pkg::*;
(
    input logic                      CLK,
    input logic                      RESET_N,
    input logic [`RV_XLEN-1:0]       q_rom,
    input logic [`RV_ADDR_WIDTH-1:0] addr_rom,
    input logic [`RV_ADDR_WIDTH-1:0] addr_ram,
    input logic [`RV_XLEN-1:0]       q_w,
    input logic                      enable_w
);

    logic straight_line; // Instruction that cannot redirect the PC

    assign straight_line = (q_rom[6:0] != BRANCH) && (q_rom[6:0] != JAL);

    a_no_write_in_reset: assert property (@(posedge CLK) !RESET_N |-> !enable_w)
        else $error("enable_w high while RESET_N is low");

    a_start_at_zero: assert property (@(posedge CLK) $rose(RESET_N) |-> addr_rom == '0)
        else $error("addr_rom not zero after reset");

    a_write_known: assert property (@(posedge CLK) disable iff (!RESET_N)
        enable_w |-> !$isunknown({q_w, addr_ram}))
        else $error("Store address or data unknown");

    // Second cycle with RESET_N high is the first one with the core running
    a_pc_advance: assert property (@(posedge CLK) disable iff (!RESET_N)
        (RESET_N && $past(RESET_N) && straight_line)
            |=> addr_rom == `RV_ADDR_WIDTH'($past(addr_rom) + 1))
        else $error("addr_rom did not advance by one");

endmodule

bind rv_core rv_core_checker i_rv_core_checker (.*);

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/100ps

`include "rv_settings.svh"

module rv_core_tb
    import rv_isa_pkg::*;
();

    localparam int MAX_CYCLES = 2000;
    localparam int MEM_WORDS  = 1 << `RV_ADDR_WIDTH;
    // {bit 30, funct3} of each ALU operation
    localparam logic [3:0] R_OPS [10] = '{4'b0000, 4'b1000, 4'b0001, 4'b0010, 4'b0011,
                                          4'b0100, 4'b0101, 4'b1101, 4'b0110, 4'b0111};
    localparam logic [3:0] I_OPS [9]  = '{4'b0000, 4'b0001, 4'b0010, 4'b0011, 4'b0100,
                                          4'b0101, 4'b1101, 4'b0110, 4'b0111};

    typedef struct packed {
        logic [31:0] pc;
        logic        store;
        logic [31:0] addr;
        logic [31:0] data;
    } step_t;

    logic                      CLK;
    logic                      RESET_N;
    logic [`RV_XLEN-1:0]       q_rom;
    logic [`RV_ADDR_WIDTH-1:0] addr_rom;
    logic [`RV_ADDR_WIDTH-1:0] addr_ram;
    logic [`RV_XLEN-1:0]       q_ram;
    logic [`RV_XLEN-1:0]       q_w;
    logic                      enable_w;

    logic [31:0] rom [MEM_WORDS];
    logic [31:0] ram [MEM_WORDS];
    logic [31:0] model_mem [MEM_WORDS];
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;
    integer      seed;
    int          errors;
    int          checks;
    int          prog_len;
    logic        checking;  // Comparison process active
    logic        timed_out;
    step_t       exp_step;

    rv_core i_rv_core (.*);

    assign q_rom = rom[addr_rom];
    assign q_ram = ram[addr_ram];

    always @(posedge CLK) begin
        if (enable_w) ram[addr_ram] <= q_w;
    end

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error: %s is 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], STORE}; // SW with x0 base
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    // ALU result by the RV32I rules
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b011:  return {31'd0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Executes one instruction on the architectural model
    function automatic step_t ref_step();
        step_t       r;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] next;
        logic        wr;
        ins   = rom[model_pc[`RV_ADDR_WIDTH+1:2]];
        a     = model_regs[ins[19:15]];
        b     = model_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        r     = '0;
        r.pc  = model_pc;
        next  = model_pc + 4;
        wr    = 1'b0;
        res   = '0;
        case (ins[6:0])
            OP: begin
                res = ref_alu(ins[14:12], ins[30], a, b);
                wr  = 1'b1;
            end
            OP_IMM: begin
                res = ref_alu(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
                wr  = 1'b1;
            end
            LOAD: begin
                addr = a + imm_i;
                res  = model_mem[addr[`RV_ADDR_WIDTH+1:2]];
                wr   = 1'b1;
            end
            STORE: begin
                addr    = a + imm_s;
                r.store = 1'b1;
                r.addr  = addr;
                r.data  = b;
                model_mem[addr[`RV_ADDR_WIDTH+1:2]] = b;
            end
            BRANCH: begin
                if ((a == b) != ins[12])
                    next = model_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                       ins[11:8], 1'b0};
            end
            LUI: begin
                res = {ins[31:12], 12'd0};
                wr  = 1'b1;
            end
            AUIPC: begin
                res = model_pc + {ins[31:12], 12'd0};
                wr  = 1'b1;
            end
            JAL: begin
                res  = model_pc + 4;
                wr   = 1'b1;
                next = model_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                   ins[30:21], 1'b0};
            end
            default: ;
        endcase
        if (wr && ins[11:7] != 5'd0) model_regs[ins[11:7]] = res;
        model_pc = next;
        return r;
    endfunction

    always @(negedge CLK) begin
        if (checking) begin
            exp_step = ref_step();
            check("addr_rom", 32'(addr_rom), 32'(exp_step.pc[`RV_ADDR_WIDTH+1:2]));
            check("enable_w", 32'(enable_w), 32'(exp_step.store));
            if (exp_step.store) begin
                check("addr_ram", 32'(addr_ram), 32'(exp_step.addr[`RV_ADDR_WIDTH+1:2]));
                check("q_w", q_w, exp_step.data);
            end
        end
    end

    function automatic logic [4:0] rand_reg(input logic nonzero);
        logic [31:0] r;
        r = $random(seed);
        if (nonzero && r[2:0] == 3'd0) return 5'd1;
        return {2'b00, r[2:0]};
    endfunction

    task automatic emit(input logic [31:0] instr);
        rom[prog_len] = instr;
        prog_len++;
    endtask

    task automatic fill_memories();
        for (int i = 0; i < MEM_WORDS; i++) begin
            rom[i]       = enc_i(12'(i), 5'd0, 3'b000, 5'd0, OP_IMM); // ADDI x0 as filler
            ram[i]       = {~16'(i), 16'(i)};
            model_mem[i] = {~16'(i), 16'(i)};
        end
        prog_len = 0;
    endtask

    task automatic gen_alu_program();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [11:0] imm;
        int          slot;
        fill_memories();
        slot = 0;
        for (int i = 1; i < 8; i++) begin
            r = $random(seed);
            if (i == 1) r[31] = 1'b1; // x1 negative for SRA and SLT
            emit({r[31:12], 5'(i), LUI});
            emit(enc_i(r[11:0], 5'(i), 3'b000, 5'(i), OP_IMM));
        end
        for (int round = 0; round < 2; round++) begin
            for (int f = 0; f < 10; f++) begin
                rd = rand_reg(1'b0);
                emit(enc_r({1'b0, R_OPS[f][3], 5'd0}, rand_reg(1'b1), rand_reg(1'b1),
                           R_OPS[f][2:0], rd));
                emit(enc_s(12'(256 + slot * 4), rd));
                slot++;
            end
            for (int f = 0; f < 9; f++) begin
                rd  = rand_reg(1'b0);
                r   = $random(seed);
                imm = (I_OPS[f][1:0] == 2'b01) ? {1'b0, I_OPS[f][3], 5'd0, r[4:0]} : r[11:0];
                emit(enc_i(imm, rand_reg(1'b1), I_OPS[f][2:0], rd, OP_IMM));
                emit(enc_s(12'(256 + slot * 4), rd));
                slot++;
            end
        end
        emit(enc_j(21'd0, 5'd0)); // Halt loop
    endtask

    task automatic gen_mem_branch_program();
        logic [31:0] r;
        fill_memories();
        emit(enc_s(12'd0, 5'd0)); // Store as the first instruction
        r = $random(seed);
        emit({r[31:12], 5'd5, LUI});
        emit(enc_i(r[11:0], 5'd5, 3'b000, 5'd5, OP_IMM));
        emit(enc_s(12'd16, 5'd5));
        emit(enc_i(12'd16, 5'd0, 3'b010, 5'd6, LOAD));
        emit(enc_s(12'd20, 5'd6));
        emit(enc_i(12'd40, 5'd0, 3'b010, 5'd10, LOAD)); // Fill pattern word
        emit(enc_s(12'd44, 5'd10));
        emit(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OP_IMM));
        emit(enc_i(12'd5, 5'd0, 3'b000, 5'd2, OP_IMM));
        emit(enc_i(12'd7, 5'd0, 3'b000, 5'd3, OP_IMM));
        emit(enc_b(13'd8, 5'd2, 5'd1, 3'b000)); // BEQ taken
        emit(enc_s(12'd48, 5'd3));
        emit(enc_b(13'd8, 5'd3, 5'd1, 3'b000)); // BEQ not taken
        emit(enc_s(12'd52, 5'd3));
        emit(enc_b(13'd8, 5'd3, 5'd1, 3'b001)); // BNE taken
        emit(enc_s(12'd56, 5'd3));
        emit(enc_b(13'd8, 5'd2, 5'd1, 3'b001)); // BNE not taken
        emit(enc_s(12'd60, 5'd3));
        emit(enc_j(21'd12, 5'd7));
        emit(enc_s(12'd64, 5'd3));
        emit(enc_s(12'd68, 5'd3));
        emit(enc_s(12'd72, 5'd7)); // Link value
        r = $random(seed);
        emit({r[31:12], 5'd8, AUIPC});
        emit(enc_s(12'd76, 5'd8));
        emit({r[19:0], 5'd9, LUI});
        emit(enc_s(12'd80, 5'd9));
        emit(enc_j(21'd0, 5'd0));
    endtask

    task automatic run_program();
        int                        cycles;
        logic [`RV_ADDR_WIDTH-1:0] halt_addr;
        halt_addr = `RV_ADDR_WIDTH'(prog_len - 1);
        @(posedge CLK);
        RESET_N <= 1'b0;
        repeat (16) begin
            @(negedge CLK);
            check("enable_w", 32'(enable_w), 32'd0);
            check("addr_rom", 32'(addr_rom), 32'd0);
            @(posedge CLK);
        end
        RESET_N <= 1'b1;
        model_pc = '0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        @(negedge CLK);
        check("enable_w", 32'(enable_w), 32'd0); // Run flag still low
        check("addr_rom", 32'(addr_rom), 32'd0);
        @(posedge CLK); // Run flag edge
        checking = 1'b1;
        cycles   = 0;
        while (addr_rom != halt_addr && cycles < MAX_CYCLES) begin
            @(negedge CLK);
            cycles++;
        end
        @(posedge CLK);
        checking = 1'b0;
        if (addr_rom != halt_addr) begin
            timed_out = 1'b1;
            $display("Program did not reach its halt address within %0d cycles", MAX_CYCLES);
        end
    endtask

    initial begin
        RESET_N   = 1'b0;
        checking  = 1'b0;
        timed_out = 1'b0;
        errors    = 0;
        checks    = 0;
        seed      = 32'hb201_cc47;
        gen_alu_program();
        run_program();
        if (!timed_out) begin
            gen_mem_branch_program();
            run_program();
        end
        $display("Checks: %0d, errors: %0d, timeout: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+common
common/rv_isa_pkg.sv
common/rv_core_pkg.sv
decode/rv_decoder.sv
hw/rv_regfile.sv
execute/rv_execute.sv
hw/rv_core.sv
verification/rv_core_checker.sv
verification/rv_core_tb.sv

// ==== Makefile ====
# Verilator build of the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Output goes to the terminal and the pass line decides the exit status
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
